//--- verilog/renkon_pkg.sv
package renkon_pkg;

  // data widths.
  localparam int DWIDTH = 16;  // pixels and weights, signed.
  localparam int AWIDTH = 40;  // products, sums, feature words.
  localparam int LWIDTH = 10;  // sizes and coordinates.

  // filter side.
  localparam int FSIZE = 3;

  // pipeline latencies in cycles.
  localparam int D_CONV  = 2;  // conv_mac, products then sum.
  localparam int D_ACCUM = 1;  // feat_accum, read-add-write.

  // window and output strobes.
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_reg;

endpackage

//--- verilog/ctrl_conv.sv
`timescale 1ns/10ps

module ctrl_conv import renkon_pkg::*; #(
  parameter int IMG_MAX = 32,
  localparam int FADDR = $clog2((IMG_MAX - FSIZE + 1) * (IMG_MAX - FSIZE + 1))
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              start,
  input  logic              first_input,
  input  logic              last_input,
  input  logic              pixel_valid,
  input  logic [LWIDTH-1:0] img_size,
  output ctrl_reg           win_ctrl,
  output logic              feat_we,
  output logic              feat_rst,
  output logic [FADDR-1:0]  feat_addr,
  output ctrl_reg           out_ctrl,
  output logic [LWIDTH-1:0] fea_size
);

  typedef enum logic {S_WAIT, S_ACTIVE} state_t;

  state_t            r_state;
  logic              r_first;
  logic              r_last;
  logic [LWIDTH-1:0] r_img_size;
  logic [LWIDTH-1:0] r_fea_size;
  logic [LWIDTH-1:0] r_x;
  logic [LWIDTH-1:0] r_y;
  logic [FADDR-1:0]  r_win_cnt;
  ctrl_reg           r_win;
  logic              r_we_d   [0:D_CONV-1];
  logic              r_rst_d  [0:D_CONV-1];
  logic [FADDR-1:0]  r_addr_d [0:D_CONV];
  ctrl_reg           r_out_d  [0:D_CONV+D_ACCUM-1];
  logic              x_end;
  logic              last_px;
  logic              win_done;

  assign x_end    = r_x == r_img_size - LWIDTH'(1);
  assign last_px  = x_end && r_y == r_img_size - LWIDTH'(1);
  assign win_done = r_state == S_ACTIVE && pixel_valid
                    && r_x >= LWIDTH'(FSIZE - 1) && r_y >= LWIDTH'(FSIZE - 1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= S_WAIT;
    end else if (r_state == S_WAIT && start) begin
      r_state <= S_ACTIVE;
    end else if (r_state == S_ACTIVE && pixel_valid && last_px) begin
      r_state <= S_WAIT;
    end
  end

  // sizes and pass flags hold for the whole pass.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_img_size <= '0;
      r_fea_size <= '0;
      r_first    <= 1'b0;
      r_last     <= 1'b0;
    end else if (r_state == S_WAIT && start) begin
      r_img_size <= img_size;
      r_fea_size <= img_size - LWIDTH'(FSIZE - 1);
      r_first    <= first_input;
      r_last     <= last_input;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst || r_state == S_WAIT) begin
      r_x <= '0;
      r_y <= '0;
    end else if (pixel_valid) begin
      if (x_end) begin
        r_x <= '0;
        r_y <= r_y + LWIDTH'(1);
      end else begin
        r_x <= r_x + LWIDTH'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_win     <= '0;
      r_win_cnt <= '0;
    end else begin
      r_win.start <= win_done && r_x == LWIDTH'(FSIZE - 1) && r_y == LWIDTH'(FSIZE - 1);
      r_win.valid <= win_done;
      r_win.stop  <= win_done && last_px;
      if (r_state == S_WAIT && start) begin
        r_win_cnt <= '0;
      end else if (win_done) begin
        r_win_cnt <= r_win_cnt + FADDR'(1);
      end
    end
  end

  // address travels beside the window through the mac.
  always_ff @(posedge clk) begin
    if (win_done) begin
      r_addr_d[0] <= r_win_cnt;
    end
    for (int i = 1; i <= D_CONV; i++) begin
      r_addr_d[i] <= r_addr_d[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < D_CONV; i++) begin
        r_we_d[i]  <= 1'b0;
        r_rst_d[i] <= 1'b0;
      end
      for (int i = 0; i < D_CONV + D_ACCUM; i++) begin
        r_out_d[i] <= '0;
      end
    end else begin
      r_we_d[0]  <= r_win.valid;
      r_rst_d[0] <= r_win.valid && r_first;  // first pass overwrites.
      for (int i = 1; i < D_CONV; i++) begin
        r_we_d[i]  <= r_we_d[i-1];
        r_rst_d[i] <= r_rst_d[i-1];
      end
      r_out_d[0] <= r_last ? r_win : '0;  // only the last pass leaves.
      for (int i = 1; i < D_CONV + D_ACCUM; i++) begin
        r_out_d[i] <= r_out_d[i-1];
      end
    end
  end

  assign win_ctrl  = r_win;
  assign feat_we   = r_we_d[D_CONV-1];
  assign feat_rst  = r_rst_d[D_CONV-1];
  assign feat_addr = r_addr_d[D_CONV];
  assign out_ctrl  = r_out_d[D_CONV+D_ACCUM-1];
  assign fea_size  = r_fea_size;

  a_pixel_in_pass: assert property (@(posedge clk) disable iff (!xrst)
    pixel_valid |-> r_state == S_ACTIVE);

  a_size_range: assert property (@(posedge clk) disable iff (!xrst)
    start |-> img_size >= LWIDTH'(FSIZE) && img_size <= LWIDTH'(IMG_MAX));

endmodule

//--- verilog/line_window.sv
`timescale 1ns/10ps

module line_window import renkon_pkg::*; #(
  parameter int IMG_MAX = 32
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     pixel_valid,
  input  logic signed [DWIDTH-1:0] pixel,
  input  logic [LWIDTH-1:0]        img_size,
  output logic signed [DWIDTH-1:0] win [0:FSIZE*FSIZE-1]
);

  localparam int PW = $clog2(IMG_MAX);

  logic signed [DWIDTH-1:0] row_a [0:IMG_MAX-1];  // one row above.
  logic signed [DWIDTH-1:0] row_b [0:IMG_MAX-1];  // two rows above.
  logic [LWIDTH-1:0]        r_ptr;
  logic signed [DWIDTH-1:0] col_new [0:FSIZE-1];

  // ptr wraps at the row length, so a full pass leaves it at zero.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_ptr <= '0;
    end else if (pixel_valid) begin
      if (r_ptr == img_size - LWIDTH'(1)) begin
        r_ptr <= '0;
      end else begin
        r_ptr <= r_ptr + LWIDTH'(1);
      end
    end
  end

  // new right column, top to bottom.
  assign col_new[0] = row_b[r_ptr[PW-1:0]];
  assign col_new[1] = row_a[r_ptr[PW-1:0]];
  assign col_new[2] = pixel;

  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      row_a[r_ptr[PW-1:0]] <= pixel;
      row_b[r_ptr[PW-1:0]] <= row_a[r_ptr[PW-1:0]];
      for (int r = 0; r < FSIZE; r++) begin
        for (int c = 0; c < FSIZE - 1; c++) begin
          win[r*FSIZE+c] <= win[r*FSIZE+c+1];
        end
        win[r*FSIZE+FSIZE-1] <= col_new[r];
      end
    end
  end

  a_row_fits: assert property (@(posedge clk) disable iff (!xrst)
    pixel_valid |-> img_size <= LWIDTH'(IMG_MAX));

endmodule

//--- verilog/conv_mac.sv
`timescale 1ns/10ps

module conv_mac import renkon_pkg::*; (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     weight_we,
  input  logic [3:0]               weight_addr,
  input  logic signed [DWIDTH-1:0] weight_data,
  input  logic                     win_valid,
  input  logic signed [DWIDTH-1:0] win [0:FSIZE*FSIZE-1],
  output logic signed [AWIDTH-1:0] conv_sum
);

  localparam int NTAP = FSIZE * FSIZE;

  logic signed [DWIDTH-1:0] r_weight [0:NTAP-1];
  logic signed [AWIDTH-1:0] r_prod   [0:NTAP-1];
  logic                     r_prod_valid;
  logic signed [AWIDTH-1:0] prod_sum;

  always_ff @(posedge clk) begin
    if (weight_we) begin
      r_weight[weight_addr] <= weight_data;
    end
  end

  // stage 1, products.
  always_ff @(posedge clk) begin
    if (win_valid) begin
      for (int i = 0; i < NTAP; i++) begin
        r_prod[i] <= AWIDTH'(win[i]) * AWIDTH'(r_weight[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_prod_valid <= 1'b0;
    end else begin
      r_prod_valid <= win_valid;
    end
  end

  always_comb begin
    prod_sum = '0;
    for (int i = 0; i < NTAP; i++) begin
      prod_sum = prod_sum + r_prod[i];
    end
  end

  // stage 2, sum.
  always_ff @(posedge clk) begin
    if (r_prod_valid) begin
      conv_sum <= prod_sum;
    end
  end

  a_weight_addr: assert property (@(posedge clk) disable iff (!xrst)
    weight_we |-> weight_addr < 4'(NTAP));

  // weights load between passes, never under a window in flight.
  a_weight_quiet: assert property (@(posedge clk) disable iff (!xrst)
    weight_we |-> !win_valid && !r_prod_valid);

endmodule

//--- verilog/feat_accum.sv
`timescale 1ns/10ps

module feat_accum import renkon_pkg::*; #(
  parameter int IMG_MAX = 32,
  localparam int FDEPTH = (IMG_MAX - FSIZE + 1) * (IMG_MAX - FSIZE + 1),
  localparam int FADDR = $clog2(FDEPTH)
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     feat_we,
  input  logic                     feat_rst,
  input  logic [FADDR-1:0]         feat_addr,
  input  logic signed [AWIDTH-1:0] conv_sum,
  output logic signed [AWIDTH-1:0] out_data
);

  logic signed [AWIDTH-1:0] mem [0:FDEPTH-1];
  logic signed [AWIDTH-1:0] acc_base;
  logic signed [AWIDTH-1:0] acc_sum;

  assign acc_base = feat_rst ? '0 : mem[feat_addr];  // first pass starts from zero.
  assign acc_sum  = acc_base + conv_sum;

  always_ff @(posedge clk) begin
    if (feat_we) begin
      mem[feat_addr] <= acc_sum;
      out_data       <= acc_sum;
    end
  end

  a_addr_depth: assert property (@(posedge clk) disable iff (!xrst)
    feat_we |-> feat_addr < FADDR'(FDEPTH));

endmodule

//--- verilog/conv_core.sv
`timescale 1ns/10ps

module conv_core import renkon_pkg::*; #(
  parameter int IMG_MAX = 32,
  localparam int FADDR = $clog2((IMG_MAX - FSIZE + 1) * (IMG_MAX - FSIZE + 1))
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     start,
  input  logic [LWIDTH-1:0]        img_size,
  input  logic                     first_input,
  input  logic                     last_input,
  input  logic                     pixel_valid,
  input  logic signed [DWIDTH-1:0] pixel,
  input  logic                     weight_we,
  input  logic [3:0]               weight_addr,
  input  logic signed [DWIDTH-1:0] weight_data,
  output logic                     out_valid,
  output logic signed [AWIDTH-1:0] out_data,
  output logic                     out_start,
  output logic                     out_stop,
  output logic [LWIDTH-1:0]        fea_size
);

  ctrl_reg                  win_ctrl;
  ctrl_reg                  out_ctrl;
  logic                     feat_we;
  logic                     feat_rst;
  logic [FADDR-1:0]         feat_addr;
  logic [LWIDTH-1:0]        line_size;
  logic signed [DWIDTH-1:0] win [0:FSIZE*FSIZE-1];
  logic signed [AWIDTH-1:0] conv_sum;

  // latched image side, rebuilt from the feature size.
  assign line_size = fea_size + LWIDTH'(FSIZE - 1);

  ctrl_conv #(.IMG_MAX(IMG_MAX)) u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .first_input (first_input),
    .last_input  (last_input),
    .pixel_valid (pixel_valid),
    .img_size    (img_size),
    .win_ctrl    (win_ctrl),
    .feat_we     (feat_we),
    .feat_rst    (feat_rst),
    .feat_addr   (feat_addr),
    .out_ctrl    (out_ctrl),
    .fea_size    (fea_size)
  );

  line_window #(.IMG_MAX(IMG_MAX)) u_window (
    .clk         (clk),
    .xrst        (xrst),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .img_size    (line_size),
    .win         (win)
  );

  conv_mac u_mac (
    .clk         (clk),
    .xrst        (xrst),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .win_valid   (win_ctrl.valid),
    .win         (win),
    .conv_sum    (conv_sum)
  );

  feat_accum #(.IMG_MAX(IMG_MAX)) u_accum (
    .clk       (clk),
    .xrst      (xrst),
    .feat_we   (feat_we),
    .feat_rst  (feat_rst),
    .feat_addr (feat_addr),
    .conv_sum  (conv_sum),
    .out_data  (out_data)
  );

  assign out_valid = out_ctrl.valid;
  assign out_start = out_ctrl.start;
  assign out_stop  = out_ctrl.stop;

endmodule

//--- verification/conv_core_tb.sv
`timescale 1ns/10ps

module conv_core_tb import renkon_pkg::*; ();

  localparam int OUT_LATENCY = 4;  // completing pixel to out_valid.
  localparam int MAX_PIX     = 64;  // largest image here is 8x8.
  localparam int TOTAL_PIX   = 9 + 25 + 64 + 3 * 36;
  localparam int NUM_PASS    = 6;
  localparam int CYCLE_LIMIT = 4 * TOTAL_PIX + 32 * NUM_PASS + 50;

  logic                     clk;
  logic                     xrst;
  logic                     start;
  logic [LWIDTH-1:0]        img_size;
  logic                     first_input;
  logic                     last_input;
  logic                     pixel_valid;
  logic signed [DWIDTH-1:0] pixel;
  logic                     weight_we;
  logic [3:0]               weight_addr;
  logic signed [DWIDTH-1:0] weight_data;
  logic                     out_valid;
  logic signed [AWIDTH-1:0] out_data;
  logic                     out_start;
  logic                     out_stop;
  logic [LWIDTH-1:0]        fea_size;

  logic [31:0]              lfsr_state;
  logic signed [DWIDTH-1:0] img_store [0:2][0:MAX_PIX-1];
  logic signed [DWIDTH-1:0] w_store   [0:2][0:FSIZE*FSIZE-1];
  longint                   exp_arr   [0:MAX_PIX-1];
  int                       nout = 0;
  int                       out_idx = 0;
  int                       out_checked = 0;
  int                       start_cnt = 0;
  int                       stop_cnt = 0;
  int                       drv_errors = 0;
  int                       mon_errors = 0;
  int                       tick_count = 0;
  int                       mon_cyc = 0;
  int                       win_q [$];  // cycles of window-completing pixels.
  logic                     in_last = 1'b0;
  int                       msize = 0;
  int                       mx = 0;
  int                       my = 0;

  conv_core #(.IMG_MAX(32)) uut (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .img_size    (img_size),
    .first_input (first_input),
    .last_input  (last_input),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_start   (out_start),
    .out_stop    (out_stop),
    .fea_size    (fea_size)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // valid 3x3 convolution at (fx, fy), summed over the passes.
  function automatic longint conv_ref(int size, int npass, int fx, int fy);
    longint acc;
    acc = 0;
    for (int p = 0; p < npass; p++) begin
      for (int r = 0; r < FSIZE; r++) begin
        for (int c = 0; c < FSIZE; c++) begin
          acc += longint'(img_store[p][(fy + r) * size + fx + c])
                 * longint'(w_store[p][r * FSIZE + c]);
        end
      end
    end
    return acc;
  endfunction

  task automatic load_weights(int p);
    for (int k = 0; k < FSIZE * FSIZE; k++) begin
      weight_we   = 1'b1;
      weight_addr = 4'(k);
      weight_data = w_store[p][k];
      @(negedge clk);
    end
    weight_we = 1'b0;
  endtask

  task automatic drive_pass(int size, int p, logic first, logic last);
    int gap;
    start       = 1'b1;
    img_size    = LWIDTH'(size);
    first_input = first;
    last_input  = last;
    @(negedge clk);
    start = 1'b0;
    assert (fea_size === LWIDTH'(size - 2)) else begin
      drv_errors++;
      $display("** Error: fea_size = %h, expected %h", fea_size, LWIDTH'(size - 2));
    end
    for (int i = 0; i < size * size; i++) begin
      gap = int'(rand_bits(2));
      repeat (gap) @(negedge clk);
      pixel_valid = 1'b1;
      pixel       = img_store[p][i];
      @(negedge clk);
      pixel_valid = 1'b0;
    end
    if (last) begin
      while (out_idx < nout) @(negedge clk);
    end else begin
      repeat (OUT_LATENCY + 1) @(negedge clk);  // let the pipeline drain.
    end
  endtask

  task automatic run_test(int size, int npass);
    int fsz;
    fsz = size - 2;
    for (int p = 0; p < npass; p++) begin
      for (int k = 0; k < FSIZE * FSIZE; k++) begin
        w_store[p][k] = DWIDTH'(rand_bits(DWIDTH));
      end
      for (int i = 0; i < size * size; i++) begin
        img_store[p][i] = DWIDTH'(rand_bits(DWIDTH));
      end
    end
    for (int p = 0; p < npass; p++) begin
      load_weights(p);
      if (p == npass - 1) begin
        nout = fsz * fsz;
        for (int fy = 0; fy < fsz; fy++) begin
          for (int fx = 0; fx < fsz; fx++) begin
            exp_arr[fy * fsz + fx] = conv_ref(size, npass, fx, fy);
          end
        end
      end
      drive_pass(size, p, p == 0, p == npass - 1);
    end
    assert (start_cnt == 1 && stop_cnt == 1) else begin
      drv_errors++;
      $display("size %0d: out_start seen %0d times and out_stop %0d times, expected once each",
               size, start_cnt, stop_cnt);
    end
  endtask

  initial begin
    lfsr_state  = 32'hb5f0_4062;
    xrst        = 1'b0;
    start       = 1'b0;
    img_size    = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    pixel_valid = 1'b0;
    pixel       = '0;
    weight_we   = 1'b0;
    weight_addr = '0;
    weight_data = '0;
    repeat (3) @(negedge clk);
    xrst = 1'b1;
    assert (out_valid === 1'b0 && out_start === 1'b0 && out_stop === 1'b0
            && fea_size === '0) else begin
      drv_errors++;
      $display("** Error: after reset out_valid = %h, out_start = %h, out_stop = %h, fea_size = %h",
               out_valid, out_start, out_stop, fea_size);
    end
    run_test(3, 1);
    run_test(5, 1);
    run_test(8, 1);
    run_test(6, 3);  // first, middle and last pass.
    $display("outputs checked %0d, driver errors %0d, monitor errors %0d",
             out_checked, drv_errors, mon_errors);
    if (drv_errors + mon_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  always @(posedge clk) begin
    longint exp_val;
    int     pix_cyc;
    mon_cyc++;
    if (xrst) begin
      if (start) begin
        in_last = last_input;
        msize   = int'(img_size);
        mx      = 0;
        my      = 0;
        if (last_input) begin
          out_idx   = 0;
          start_cnt = 0;
          stop_cnt  = 0;
          win_q.delete();
        end
      end
      if (pixel_valid) begin
        if (in_last && mx >= FSIZE - 1 && my >= FSIZE - 1) begin
          win_q.push_back(mon_cyc);
        end
        if (mx == msize - 1) begin
          mx = 0;
          my++;
        end else begin
          mx++;
        end
      end
      if (out_start) start_cnt++;
      if (out_stop) stop_cnt++;
      if (out_valid) begin
        assert (out_idx < nout) else begin
          mon_errors++;
          $display("output at cycle %0d while no result is pending", mon_cyc);
        end
        if (out_idx < nout) begin
          exp_val = exp_arr[out_idx];
          pix_cyc = -1;
          if (win_q.size() > 0) pix_cyc = win_q.pop_front();
          assert (out_data === AWIDTH'(exp_val)) else begin
            mon_errors++;
            $display("** Error: out_data = %h, expected %h at output %0d",
                     out_data, AWIDTH'(exp_val), out_idx);
          end
          assert (out_start === (out_idx == 0)) else begin
            mon_errors++;
            $display("** Error: out_start = %h, expected %h at output %0d",
                     out_start, out_idx == 0, out_idx);
          end
          assert (out_stop === (out_idx == nout - 1)) else begin
            mon_errors++;
            $display("** Error: out_stop = %h, expected %h at output %0d",
                     out_stop, out_idx == nout - 1, out_idx);
          end
          assert (mon_cyc - pix_cyc == OUT_LATENCY) else begin
            mon_errors++;
            $display("output %0d came %0d cycles after its pixel, expected %0d",
                     out_idx, mon_cyc - pix_cyc, OUT_LATENCY);
          end
          out_idx++;
          out_checked++;
        end
      end else begin
        assert (!out_start && !out_stop) else begin
          mon_errors++;
          $display("out_start or out_stop raised without out_valid at cycle %0d", mon_cyc);
        end
      end
    end
  end

  always @(posedge clk) begin
    tick_count++;
    if (tick_count >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("outputs checked %0d, driver errors %0d, monitor errors %0d",
               out_checked, drv_errors, mon_errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

//--- conv_core.f
verilog/renkon_pkg.sv
verilog/ctrl_conv.sv
verilog/line_window.sv
verilog/conv_mac.sv
verilog/feat_accum.sv
verilog/conv_core.sv
verification/conv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module conv_core_tb -f conv_core.f -o conv_core_sim

./obj_dir/conv_core_sim > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
exit 0
